// File: hw/core_pkg.sv
package core_pkg;

    localparam int xlen = 32;
    localparam int pair_width = 64;
    localparam int num_regs = 32;

    localparam logic [xlen-1:0] pc_step = xlen'(8);
    localparam logic [xlen-1:0] reset_pc = '0;

    typedef logic [4:0] reg_addr_t;

    // Major opcodes in instruction bits 31:26.
    typedef enum logic [5:0] {
        op_rtype = 6'h00,
        op_addi  = 6'h08,
        op_slti  = 6'h0a,
        op_andi  = 6'h0c,
        op_ori   = 6'h0d,
        op_xori  = 6'h0e,
        op_sw    = 6'h2b
    } opcode_e;

    // R-type function field in bits 5:0.
    typedef enum logic [5:0] {
        fn_add = 6'h20,
        fn_sub = 6'h22,
        fn_and = 6'h24,
        fn_or  = 6'h25,
        fn_xor = 6'h26,
        fn_nor = 6'h27,
        fn_slt = 6'h2a
    } funct_e;

    typedef enum logic [2:0] {
        alu_add = 3'd0,
        alu_sub = 3'd1,
        alu_and = 3'd2,
        alu_or  = 3'd3,
        alu_xor = 3'd4,
        alu_nor = 3'd5,
        alu_slt = 3'd6
    } alu_op_e;

endpackage

// File: hw/fetch_unit.sv
module fetch_unit import core_pkg::*; (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic [pair_width-1:0] inst,
    output logic [xlen-1:0]       inst_adr,
    output logic [xlen-1:0]       id_inst_p1,
    output logic [xlen-1:0]       id_inst_p2
);

    logic [xlen-1:0] pc;
    logic [xlen-1:0] pc_next;

    assign pc_next = pc + pc_step; // The PC only steps without branches.
    assign inst_adr = pc;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= reset_pc;
        end else begin
            pc <= pc_next;
        end
    end

    // IF/ID pair register.
    // A cleared word decodes as a no-op.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            id_inst_p1 <= '0;
            id_inst_p2 <= '0;
        end else begin
            id_inst_p1 <= inst[xlen-1:0];      // Low word.
            id_inst_p2 <= inst[2*xlen-1:xlen]; // High word.
        end
    end

endmodule

// File: hw/instr_decoder.sv
module instr_decoder import core_pkg::*; (
    input  logic [xlen-1:0] inst_word,
    output reg_addr_t       rs,
    output reg_addr_t       rt,
    output reg_addr_t       dest,
    output alu_op_e         alu_op,
    output logic            use_imm,
    output logic [xlen-1:0] imm,
    output logic            reg_write,
    output logic            store
);

    opcode_e opcode;
    funct_e  funct;
    logic    sign_imm;
    logic    op_known;

    assign opcode = opcode_e'(inst_word[31:26]);
    assign funct = funct_e'(inst_word[5:0]);
    assign rs = inst_word[25:21];
    assign rt = inst_word[20:16];

    always_comb begin
        alu_op = alu_add;
        use_imm = 1'b0;
        sign_imm = 1'b1;
        reg_write = 1'b0;
        store = 1'b0;
        dest = inst_word[20:16]; // Immediates write rt.
        op_known = 1'b1;
        case (opcode)
            op_rtype: begin
                dest = inst_word[15:11];
                reg_write = 1'b1;
                case (funct)
                    fn_add:  alu_op = alu_add;
                    fn_sub:  alu_op = alu_sub;
                    fn_and:  alu_op = alu_and;
                    fn_or:   alu_op = alu_or;
                    fn_xor:  alu_op = alu_xor;
                    fn_nor:  alu_op = alu_nor;
                    fn_slt:  alu_op = alu_slt;
                    default: reg_write = 1'b0; // Includes the all-zero word.
                endcase
            end
            op_addi: begin
                use_imm = 1'b1;
                reg_write = 1'b1;
            end
            op_slti: begin
                alu_op = alu_slt;
                use_imm = 1'b1;
                reg_write = 1'b1;
            end
            op_andi, op_ori, op_xori: begin
                alu_op = (opcode == op_andi) ? alu_and :
                         (opcode == op_ori)  ? alu_or  : alu_xor;
                use_imm = 1'b1;
                sign_imm = 1'b0;
                reg_write = 1'b1;
            end
            op_sw: begin
                use_imm = 1'b1; // Address is rs plus offset.
                store = 1'b1;
            end
            default: op_known = 1'b0;
        endcase
        if (!$isunknown(inst_word)) begin
            assert (op_known)
                else $error("unknown opcode %h", inst_word[31:26]);
        end
    end

    assign imm = sign_imm ? {{(xlen-16){inst_word[15]}}, inst_word[15:0]}
                          : {{(xlen-16){1'b0}}, inst_word[15:0]};

endmodule

// File: hw/reg_file.sv
module reg_file import core_pkg::*; (
    input  logic                       clk,
    input  logic                       arst_n,
    input  reg_addr_t [3:0]            rd_addr,
    output logic      [3:0][xlen-1:0]  rd_data,
    input  logic                       wr_en_p1,
    input  logic                       wr_en_p2,
    input  reg_addr_t                  wr_addr_p1,
    input  reg_addr_t                  wr_addr_p2,
    input  logic      [xlen-1:0]       wr_data_p1,
    input  logic      [xlen-1:0]       wr_data_p2
);

    logic [num_regs-1:0][xlen-1:0] regs;

    // Lane 2 is written last, so it wins on a shared address.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            regs <= '0;
        end else begin
            if (wr_en_p1 && wr_addr_p1 != '0) begin
                regs[wr_addr_p1] <= wr_data_p1;
            end
            if (wr_en_p2 && wr_addr_p2 != '0) begin
                regs[wr_addr_p2] <= wr_data_p2;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            rd_data[i] = (rd_addr[i] == '0) ? '0 : regs[rd_addr[i]];
        end
    end

endmodule

// File: hw/operand_forward.sv
module operand_forward import core_pkg::*; (
    input  reg_addr_t       rs,
    input  reg_addr_t       rt,
    input  logic [xlen-1:0] rf_src1,
    input  logic [xlen-1:0] rf_src2,
    input  logic            use_imm,
    input  logic [xlen-1:0] imm,
    input  logic            ex_we_p1,
    input  reg_addr_t       ex_dest_p1,
    input  logic [xlen-1:0] ex_result_p1,
    input  logic            ex_we_p2,
    input  reg_addr_t       ex_dest_p2,
    input  logic [xlen-1:0] ex_result_p2,
    input  logic            mem_we_p1,
    input  reg_addr_t       mem_dest_p1,
    input  logic [xlen-1:0] mem_result_p1,
    input  logic            mem_we_p2,
    input  reg_addr_t       mem_dest_p2,
    input  logic [xlen-1:0] mem_result_p2,
    input  logic            wb_we_p1,
    input  reg_addr_t       wb_dest_p1,
    input  logic [xlen-1:0] wb_result_p1,
    input  logic            wb_we_p2,
    input  reg_addr_t       wb_dest_p2,
    input  logic [xlen-1:0] wb_result_p2,
    output logic [xlen-1:0] op1,
    output logic [xlen-1:0] op2,
    output logic [xlen-1:0] store_data
);

    // Ordered oldest first so a later match overrides an earlier one.
    logic      [5:0]            fw_we;
    reg_addr_t [5:0]            fw_dest;
    logic      [5:0][xlen-1:0]  fw_val;
    logic      [xlen-1:0]       src2;

    assign fw_we = {ex_we_p2, ex_we_p1, mem_we_p2, mem_we_p1, wb_we_p2, wb_we_p1};
    assign fw_dest = {ex_dest_p2, ex_dest_p1, mem_dest_p2, mem_dest_p1,
                      wb_dest_p2, wb_dest_p1};
    assign fw_val = {ex_result_p2, ex_result_p1, mem_result_p2, mem_result_p1,
                     wb_result_p2, wb_result_p1};

    function automatic logic [xlen-1:0] resolve(reg_addr_t addr, logic [xlen-1:0] rf_val,
                                                logic [5:0] we, reg_addr_t [5:0] dst,
                                                logic [5:0][xlen-1:0] val);
        logic [xlen-1:0] res;
        res = rf_val;
        for (int i = 0; i < 6; i++) begin
            if (we[i] && dst[i] == addr && addr != '0) res = val[i];
        end
        return res;
    endfunction

    assign op1 = resolve(rs, rf_src1, fw_we, fw_dest, fw_val);
    assign src2 = resolve(rt, rf_src2, fw_we, fw_dest, fw_val);
    assign op2 = use_imm ? imm : src2;
    assign store_data = src2; // sw writes rt.

endmodule

// File: hw/alu.sv
module alu import core_pkg::*; (
    input  logic [xlen-1:0] a,
    input  logic [xlen-1:0] b,
    input  alu_op_e         op,
    output logic [xlen-1:0] y
);

    logic lt;

    assign lt = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            alu_add: y = a + b;
            alu_sub: y = a - b;
            alu_and: y = a & b;
            alu_or:  y = a | b;
            alu_xor: y = a ^ b;
            alu_nor: y = ~(a | b);
            alu_slt: y = {{(xlen-1){1'b0}}, lt}; // Signed compare.
            default: y = '0;
        endcase
    end

endmodule

// File: hw/lane_backend.sv
module lane_backend import core_pkg::*; #(
    parameter bit has_store = 1'b0
) (
    input  logic            clk,
    input  logic            arst_n,
    input  logic [xlen-1:0] op1,
    input  logic [xlen-1:0] op2,
    input  logic [xlen-1:0] store_data,
    input  alu_op_e         alu_op,
    input  reg_addr_t       dest,
    input  logic            reg_write,
    input  logic            store,
    output logic            ex_we,
    output logic            mem_we,
    output logic            wb_we,
    output reg_addr_t       ex_dest,
    output reg_addr_t       mem_dest,
    output reg_addr_t       wb_dest,
    output logic [xlen-1:0] ex_result,
    output logic [xlen-1:0] mem_result,
    output logic [xlen-1:0] wb_result,
    output logic            mem_write,
    output logic [xlen-1:0] data_adr,
    output logic [xlen-1:0] data_out
);

    logic [xlen-1:0] idex_a;
    logic [xlen-1:0] idex_b;
    alu_op_e         idex_op;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            idex_a <= '0;
            idex_b <= '0;
            idex_op <= alu_add;
            ex_dest <= '0;
            ex_we <= 1'b0;
            mem_result <= '0;
            mem_dest <= '0;
            mem_we <= 1'b0;
            wb_result <= '0;
            wb_dest <= '0;
            wb_we <= 1'b0;
        end else begin
            idex_a <= op1;        // ID/EX.
            idex_b <= op2;
            idex_op <= alu_op;
            ex_dest <= dest;
            ex_we <= reg_write;
            mem_result <= ex_result; // EX/MEM.
            mem_dest <= ex_dest;
            mem_we <= ex_we;
            wb_result <= mem_result; // MEM/WB.
            wb_dest <= mem_dest;
            wb_we <= mem_we;
        end
    end

    alu u_alu (
        .a  (idex_a),
        .b  (idex_b),
        .op (idex_op),
        .y  (ex_result)
    );

    assign data_adr = has_store ? mem_result : '0;

    if (has_store) begin : g_store
        logic            idex_store;
        logic [xlen-1:0] idex_sd;
        logic            exmem_store;
        logic [xlen-1:0] exmem_sd;

        always_ff @(posedge clk or negedge arst_n) begin
            if (!arst_n) begin
                idex_store <= 1'b0;
                idex_sd <= '0;
                exmem_store <= 1'b0;
                exmem_sd <= '0;
            end else begin
                idex_store <= store;
                idex_sd <= store_data;
                exmem_store <= idex_store;
                exmem_sd <= idex_sd;
            end
        end

        assign mem_write = exmem_store;
        assign data_out = exmem_sd;
    end else begin : g_no_store
        assign mem_write = 1'b0;
        assign data_out = '0;

        // Stores only issue in the lane with the data port.
        a_no_store: assert property (@(posedge clk) disable iff (!arst_n) !store)
            else $error("store decoded in a lane without a data port");
    end

endmodule

// File: hw/dual_issue_core.sv
module dual_issue_core import core_pkg::*; (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic [pair_width-1:0] inst,
    output logic [xlen-1:0]       inst_adr,
    output logic                  mem_write,
    output logic [xlen-1:0]       data_adr,
    output logic [xlen-1:0]       data_out
);

    logic [xlen-1:0]      id_inst_p1, id_inst_p2;
    reg_addr_t            rs_p1, rt_p1, dest_p1;
    reg_addr_t            rs_p2, rt_p2, dest_p2;
    alu_op_e              alu_op_p1, alu_op_p2;
    logic                 use_imm_p1, use_imm_p2;
    logic                 reg_write_p1, reg_write_p2;
    logic                 store_p1, store_p2;
    logic [xlen-1:0]      imm_p1, imm_p2;
    logic [3:0][xlen-1:0] rf_data;
    logic [xlen-1:0]      op1_p1, op2_p1, sd_p1;
    logic [xlen-1:0]      op1_p2, op2_p2, sd_p2;
    logic                 ex_we_p1, mem_we_p1, wb_we_p1;
    logic                 ex_we_p2, mem_we_p2, wb_we_p2;
    reg_addr_t            ex_dest_p1, mem_dest_p1, wb_dest_p1;
    reg_addr_t            ex_dest_p2, mem_dest_p2, wb_dest_p2;
    logic [xlen-1:0]      ex_res_p1, mem_res_p1, wb_res_p1;
    logic [xlen-1:0]      ex_res_p2, mem_res_p2, wb_res_p2;

    fetch_unit u_fetch (
        .clk(clk), .arst_n(arst_n), .inst(inst), .inst_adr(inst_adr),
        .id_inst_p1(id_inst_p1), .id_inst_p2(id_inst_p2)
    );

    instr_decoder u_dec_p1 (
        .inst_word(id_inst_p1), .rs(rs_p1), .rt(rt_p1), .dest(dest_p1),
        .alu_op(alu_op_p1), .use_imm(use_imm_p1), .imm(imm_p1),
        .reg_write(reg_write_p1), .store(store_p1)
    );

    instr_decoder u_dec_p2 (
        .inst_word(id_inst_p2), .rs(rs_p2), .rt(rt_p2), .dest(dest_p2),
        .alu_op(alu_op_p2), .use_imm(use_imm_p2), .imm(imm_p2),
        .reg_write(reg_write_p2), .store(store_p2)
    );

    // Read ports 0 and 1 serve lane 1, ports 2 and 3 lane 2.
    reg_file u_rf (
        .clk(clk), .arst_n(arst_n), .rd_addr({rt_p2, rs_p2, rt_p1, rs_p1}),
        .rd_data(rf_data), .wr_en_p1(wb_we_p1), .wr_en_p2(wb_we_p2),
        .wr_addr_p1(wb_dest_p1), .wr_addr_p2(wb_dest_p2),
        .wr_data_p1(wb_res_p1), .wr_data_p2(wb_res_p2)
    );

    operand_forward u_fwd_p1 (
        .rs(rs_p1), .rt(rt_p1), .rf_src1(rf_data[0]), .rf_src2(rf_data[1]),
        .use_imm(use_imm_p1), .imm(imm_p1),
        .ex_we_p1(ex_we_p1), .ex_dest_p1(ex_dest_p1), .ex_result_p1(ex_res_p1),
        .ex_we_p2(ex_we_p2), .ex_dest_p2(ex_dest_p2), .ex_result_p2(ex_res_p2),
        .mem_we_p1(mem_we_p1), .mem_dest_p1(mem_dest_p1), .mem_result_p1(mem_res_p1),
        .mem_we_p2(mem_we_p2), .mem_dest_p2(mem_dest_p2), .mem_result_p2(mem_res_p2),
        .wb_we_p1(wb_we_p1), .wb_dest_p1(wb_dest_p1), .wb_result_p1(wb_res_p1),
        .wb_we_p2(wb_we_p2), .wb_dest_p2(wb_dest_p2), .wb_result_p2(wb_res_p2),
        .op1(op1_p1), .op2(op2_p1), .store_data(sd_p1)
    );

    operand_forward u_fwd_p2 (
        .rs(rs_p2), .rt(rt_p2), .rf_src1(rf_data[2]), .rf_src2(rf_data[3]),
        .use_imm(use_imm_p2), .imm(imm_p2),
        .ex_we_p1(ex_we_p1), .ex_dest_p1(ex_dest_p1), .ex_result_p1(ex_res_p1),
        .ex_we_p2(ex_we_p2), .ex_dest_p2(ex_dest_p2), .ex_result_p2(ex_res_p2),
        .mem_we_p1(mem_we_p1), .mem_dest_p1(mem_dest_p1), .mem_result_p1(mem_res_p1),
        .mem_we_p2(mem_we_p2), .mem_dest_p2(mem_dest_p2), .mem_result_p2(mem_res_p2),
        .wb_we_p1(wb_we_p1), .wb_dest_p1(wb_dest_p1), .wb_result_p1(wb_res_p1),
        .wb_we_p2(wb_we_p2), .wb_dest_p2(wb_dest_p2), .wb_result_p2(wb_res_p2),
        .op1(op1_p2), .op2(op2_p2), .store_data(sd_p2)
    );

    lane_backend #(.has_store(1'b0)) u_lane_p1 (
        .clk(clk), .arst_n(arst_n), .op1(op1_p1), .op2(op2_p1), .store_data(sd_p1),
        .alu_op(alu_op_p1), .dest(dest_p1), .reg_write(reg_write_p1), .store(store_p1),
        .ex_we(ex_we_p1), .mem_we(mem_we_p1), .wb_we(wb_we_p1),
        .ex_dest(ex_dest_p1), .mem_dest(mem_dest_p1), .wb_dest(wb_dest_p1),
        .ex_result(ex_res_p1), .mem_result(mem_res_p1), .wb_result(wb_res_p1),
        .mem_write(), .data_adr(), .data_out()
    );

    lane_backend #(.has_store(1'b1)) u_lane_p2 (
        .clk(clk), .arst_n(arst_n), .op1(op1_p2), .op2(op2_p2), .store_data(sd_p2),
        .alu_op(alu_op_p2), .dest(dest_p2), .reg_write(reg_write_p2), .store(store_p2),
        .ex_we(ex_we_p2), .mem_we(mem_we_p2), .wb_we(wb_we_p2),
        .ex_dest(ex_dest_p2), .mem_dest(mem_dest_p2), .wb_dest(wb_dest_p2),
        .ex_result(ex_res_p2), .mem_result(mem_res_p2), .wb_result(wb_res_p2),
        .mem_write(mem_write), .data_adr(data_adr), .data_out(data_out)
    );

endmodule

// File: dv/tb_clock.sv
module tb_clock (
    output logic clk,
    output logic arst_n
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int reset_cycles = 10;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk; // 10 ns period.
    end

    initial begin
        arst_n <= 1'b0;
        repeat (reset_cycles) @(posedge clk);
        arst_n <= 1'b1;
    end

endmodule

// File: dv/tb_top.sv
module tb_top import core_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int n_pairs = 28;
    localparam int store_latency = 3;
    localparam int timeout_cycles = n_pairs + 20;
    localparam int done_cycle = n_pairs + store_latency + 2;

    logic                  clk;
    logic                  arst_n;
    logic [pair_width-1:0] inst;
    logic [xlen-1:0]       inst_adr;
    logic                  mem_write;
    logic [xlen-1:0]       data_adr;
    logic [xlen-1:0]       data_out;

    logic [31:0] prog_p1 [n_pairs];
    logic [31:0] prog_p2 [n_pairs];
    logic [31:0] model_rf [32];
    logic [15:0] lfsr;
    int          exp_idx [$];
    logic [31:0] exp_adr [$];
    logic [31:0] exp_data [$];
    int          cyc = 0;
    logic        expect_store;
    logic        in_rom;
    logic [4:0]  rom_idx;

    tb_clock u_clk (
        .clk    (clk),
        .arst_n (arst_n)
    );

    dual_issue_core dut (
        .clk       (clk),
        .arst_n    (arst_n),
        .inst      (inst),
        .inst_adr  (inst_adr),
        .mem_write (mem_write),
        .data_adr  (data_adr),
        .data_out  (data_out)
    );

    // Instruction ROM that reads zero past the program.
    assign in_rom = inst_adr < 32'(n_pairs * 8);
    assign rom_idx = inst_adr[7:3];
    assign inst = in_rom ? {prog_p2[rom_idx], prog_p1[rom_idx]} : '0;

    function automatic logic [31:0] enc_r(funct_e fn, int rd, int rs, int rt);
        return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
    endfunction

    function automatic logic [31:0] enc_i(opcode_e op, int rt, int rs);
        return {op, 5'(rs), 5'(rt), 16'h0000}; // Immediate filled later.
    endfunction

    // Fibonacci LFSR with taps x^16 + x^14 + x^13 + x^11 + 1.
    function logic [15:0] lfsr_bits(int n);
        logic [15:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            v = {v[14:0], fb};
        end
        return v;
    endfunction

    task automatic set_pair(int k, logic [31:0] w1, logic [31:0] w2);
        prog_p1[k] = w1;
        prog_p2[k] = w2;
    endtask

    // Sequential ISA model of one instruction.
    task automatic model_exec(logic [31:0] w, int k);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sext;
        logic [31:0] zext;
        logic [31:0] res;
        logic [4:0]  dst;
        logic        wr;
        a = model_rf[w[25:21]];
        b = model_rf[w[20:16]];
        sext = {{16{w[15]}}, w[15:0]};
        zext = {16'h0000, w[15:0]};
        dst = w[20:16];
        wr = 1'b1;
        res = '0;
        case (w[31:26])
            op_rtype: begin
                dst = w[15:11];
                case (w[5:0])
                    fn_add:  res = a + b;
                    fn_sub:  res = a - b;
                    fn_and:  res = a & b;
                    fn_or:   res = a | b;
                    fn_xor:  res = a ^ b;
                    fn_nor:  res = ~(a | b);
                    fn_slt:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default: wr = 1'b0;
                endcase
            end
            op_addi: res = a + sext;
            op_slti: res = ($signed(a) < $signed(sext)) ? 32'd1 : 32'd0;
            op_andi: res = a & zext;
            op_ori:  res = a | zext;
            op_xori: res = a ^ zext;
            op_sw: begin
                wr = 1'b0;
                exp_idx.push_back(k);
                exp_adr.push_back(a + sext);
                exp_data.push_back(b);
            end
            default: wr = 1'b0;
        endcase
        if (wr && dst != 5'd0) model_rf[dst] = res; // r0 stays zero.
    endtask

    task automatic report_mismatch(string name, logic [31:0] exp, logic [31:0] act);
        $display("FAILED %s: expected %h, actual %h at cycle %0d", name, exp, act, cyc);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic report_error(string msg);
        $display("ERROR: %s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    initial begin
        lfsr = 16'd62441;
        for (int k = 0; k < n_pairs; k++) set_pair(k, '0, '0);
        set_pair(0, enc_i(op_addi, 1, 0), enc_i(op_addi, 2, 0));
        set_pair(1, enc_i(op_ori, 3, 0), enc_i(op_sw, 1, 0));      // EX forward.
        set_pair(2, enc_i(op_xori, 4, 1), enc_i(op_sw, 2, 0));     // MEM forward.
        set_pair(3, enc_i(op_andi, 5, 2), enc_i(op_sw, 3, 0));
        set_pair(4, enc_r(fn_add, 6, 1, 2), enc_i(op_sw, 4, 0));
        set_pair(5, enc_r(fn_sub, 7, 6, 3), enc_i(op_sw, 5, 0));
        set_pair(6, enc_r(fn_slt, 8, 7, 1), enc_i(op_sw, 6, 0));
        set_pair(7, enc_r(fn_and, 9, 6, 7), enc_i(op_sw, 7, 0));
        set_pair(8, enc_r(fn_or, 10, 9, 2), enc_i(op_sw, 8, 0));
        set_pair(9, enc_r(fn_xor, 11, 10, 1), enc_r(fn_nor, 12, 9, 2));
        set_pair(10, enc_i(op_slti, 13, 7), enc_i(op_sw, 9, 0));
        set_pair(11, enc_i(op_addi, 14, 0), enc_i(op_sw, 10, 0));  // WB forward.
        set_pair(12, enc_i(op_addi, 16, 0), enc_i(op_addi, 16, 0));
        set_pair(13, '0, enc_i(op_sw, 16, 0));                     // Lane 2 wins.
        set_pair(14, enc_i(op_addi, 0, 0), enc_i(op_sw, 11, 0));
        set_pair(15, '0, enc_i(op_sw, 0, 0));                      // r0 not forwarded.
        set_pair(16, enc_i(op_addi, 18, 0), enc_i(op_addi, 19, 0));
        set_pair(17, enc_i(op_addi, 18, 18), enc_i(op_sw, 12, 0));
        set_pair(18, '0, enc_i(op_sw, 18, 0));                     // Youngest wins.
        set_pair(19, enc_r(fn_nor, 17, 0, 0), enc_i(op_sw, 13, 0));
        set_pair(20, enc_r(fn_nor, 0, 0, 0), enc_i(op_sw, 14, 0)); // r0 write in flight.
        set_pair(21, enc_r(fn_add, 17, 0, 0), enc_i(op_sw, 19, 0)); // From the file.
        set_pair(22, '0, enc_i(op_sw, 17, 0));                     // EX zero beats WB.
        set_pair(23, '0, enc_i(op_sw, 16, 0));                     // Lane 2 wins in the file.
        for (int k = 0; k < n_pairs; k++) begin
            if (prog_p1[k][31:26] != 6'h00) prog_p1[k][15:0] = lfsr_bits(16);
            if (prog_p2[k][31:26] != 6'h00) prog_p2[k][15:0] = lfsr_bits(16);
        end
        for (int r = 0; r < 32; r++) model_rf[r] = '0;
        for (int k = 0; k < n_pairs; k++) begin
            model_exec(prog_p1[k], k); // Lane 1 first.
            model_exec(prog_p2[k], k);
        end

        wait (cyc == done_cycle);
        if (exp_idx.size() == 0) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            report_error("expected stores never appeared");
        end
    end

    // Outputs settle after the rising edge, so they are sampled on the falling one.
    always @(negedge clk) begin
        if (arst_n) begin
            if (cyc >= timeout_cycles) report_error("run exceeded its cycle limit");
            assert (inst_adr == 32'(cyc * 8))
                else report_mismatch("fetch address", 32'(cyc * 8), inst_adr);
            expect_store = exp_idx.size() > 0 && exp_idx[0] + store_latency == cyc;
            assert (mem_write == expect_store)
                else report_mismatch("store strobe", 32'(expect_store), 32'(mem_write));
            if (expect_store) begin
                assert (data_adr == exp_adr[0])
                    else report_mismatch("store address", exp_adr[0], data_adr);
                assert (data_out == exp_data[0])
                    else report_mismatch("store data", exp_data[0], data_out);
                void'(exp_idx.pop_front());
                void'(exp_adr.pop_front());
                void'(exp_data.pop_front());
            end
            cyc <= cyc + 1;
        end
    end

endmodule

// File: files.f
hw/core_pkg.sv
hw/fetch_unit.sv
hw/instr_decoder.sv
hw/reg_file.sv
hw/operand_forward.sv
hw/alu.sv
hw/lane_backend.sv
hw/dual_issue_core.sv
dv/tb_clock.sv
dv/tb_top.sv

// File: Makefile
TOP := tb_top

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert -j 0 --top-module $(TOP) -f files.f -Mdir obj_dir

run: compile
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir
